//--- hw/wbPkg.sv
// Sizes, opcode encoding and packet format shared by every module of the writeback stage.
package wbPkg;

        localparam int NUM_LANES   = 4;          // Writeback lanes, one per unit.
        localparam int LANE_DEPTH  = 4;          // Queue slots per lane.
        localparam int CHECKPOINTS = 8;          // Branch mask width.
        localparam int CHK_W       = $clog2(CHECKPOINTS);
        localparam int TAG_W       = 6;          // Active list tag.
        localparam int PREG_W      = 6;          // Physical register index.
        localparam int DATA_W      = 32;
        localparam int PC_W        = 32;

        typedef enum logic [1:0] {
                OP_ALU,
                OP_LOAD,
                OP_BRANCH
        } fuOp_e;

        // Target and taken only mean something for OP_BRANCH.
        typedef struct packed {
                fuOp_e                  op;
                logic [CHECKPOINTS-1:0] brMask;
                logic [TAG_W-1:0]       tag;
                logic [PREG_W-1:0]      dest;
                logic [DATA_W-1:0]      data;
                logic [PC_W-1:0]        target;
                logic                   taken;
        } exePacket_t;

        // Index width, never below one bit.
        function automatic int idxWidth(input int count);
                return (count > 1) ? $clog2(count) : 1;
        endfunction

        // Width of a count running from zero up to limit.
        function automatic int cntWidth(input int limit);
                return $clog2(limit + 1);
        endfunction

endpackage

//--- hw/laneIf.sv
// Per-lane bus joining the dispatch block, one writeback lane and the collector.
interface laneIf import wbPkg::*; #(
        parameter int LANE_DEPTH = wbPkg::LANE_DEPTH
);
        localparam int CNT_W = cntWidth(LANE_DEPTH);

        logic             push;                  // One packet for this lane.
        exePacket_t       pushPkt;
        logic [CNT_W-1:0] credit;                // Slots freed last cycle.
        logic             headValid;             // Oldest live entry present.
        exePacket_t       headPkt;
        logic             pop;

        modport dispatchMp (
                output push,
                output pushPkt,
                input  credit
        );

        modport laneMp (
                input  push,
                input  pushPkt,
                input  pop,
                output credit,
                output headValid,
                output headPkt
        );

        modport collectMp (
                input  headValid,
                input  headPkt,
                output pop
        );

endinterface

//--- hw/exeDispatch.sv
// Steers completed packets to their writeback lane and tracks queue credits for each lane.
module exeDispatch import wbPkg::*; #(
        parameter int NUM_LANES   = wbPkg::NUM_LANES,
        parameter int LANE_DEPTH  = wbPkg::LANE_DEPTH,
        localparam int LANE_W     = idxWidth(NUM_LANES),
        localparam int CNT_W      = cntWidth(LANE_DEPTH)
) (
        input  logic                 clk,
        input  logic                 reset,
        input  logic                 inValid_i,
        input  logic [LANE_W-1:0]    inLane_i,
        input  exePacket_t           inPkt_i,
        output logic [NUM_LANES-1:0] laneReady_o,
        laneIf.dispatchMp            lanes [NUM_LANES]
);

        logic [CNT_W-1:0]     creditCount [NUM_LANES];
        logic [CNT_W-1:0]     returned [NUM_LANES];
        logic [NUM_LANES-1:0] pushVec;
        logic                 accept;

        assign accept = inValid_i && laneReady_o[inLane_i];

        for (genvar n = 0; n < NUM_LANES; n++)
        begin : laneGen
                assign laneReady_o[n]   = (creditCount[n] != '0);
                assign pushVec[n]       = accept && (inLane_i == LANE_W'(n));
                assign lanes[n].push    = pushVec[n];
                assign lanes[n].pushPkt = inPkt_i;
                assign returned[n]      = lanes[n].credit;
        end

        // Returned slots arrive one cycle after the lane frees them.
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        for (int n = 0; n < NUM_LANES; n++)
                        begin
                                creditCount[n] <= CNT_W'(LANE_DEPTH);
                        end
                end
                else
                begin
                        for (int n = 0; n < NUM_LANES; n++)
                        begin
                                creditCount[n] <= creditCount[n] + returned[n]
                                                  - CNT_W'(pushVec[n]);
                        end
                end
        end

endmodule

//--- hw/wbLane.sv
// One writeback lane: circular packet queue with branch squash and credit return to dispatch.
module wbLane import wbPkg::*; #(
        parameter int LANE_DEPTH = wbPkg::LANE_DEPTH
) (
        input  logic             clk,
        input  logic             reset,
        input  logic             flushValid_i,
        input  logic [CHK_W-1:0] flushCheckpoint_i,
        laneIf.laneMp            lane
);
        localparam int PTR_W = idxWidth(LANE_DEPTH);
        localparam int CNT_W = cntWidth(LANE_DEPTH);

        exePacket_t            entries [LANE_DEPTH];
        logic [LANE_DEPTH-1:0] live;
        logic [LANE_DEPTH-1:0] squashHit;
        logic [PTR_W-1:0]      headPtr;
        logic [PTR_W-1:0]      tailPtr;
        logic [PTR_W-1:0]      headIdx;
        logic [PTR_W-1:0]      slotIdx;
        logic [CNT_W-1:0]      slotCount;        // Slots between head and tail.
        logic [CNT_W-1:0]      skipCount;
        logic [CNT_W-1:0]      freeCount;
        logic                  headFound;
        logic                  pushSquash;
        logic                  pushWrite;
        logic                  popNow;

        function automatic logic [PTR_W-1:0] wrapPtr(input int value);
                return PTR_W'(value % LANE_DEPTH);
        endfunction

        always_comb
        begin
                for (int i = 0; i < LANE_DEPTH; i++)
                begin
                        squashHit[i] = flushValid_i && entries[i].brMask[flushCheckpoint_i];
                end
        end

        // Walk from the head past dead slots to the oldest live entry.
        always_comb
        begin
                headFound = 1'b0;
                skipCount = '0;
                slotIdx   = headPtr;
                for (int i = 0; i < LANE_DEPTH; i++)
                begin
                        slotIdx = wrapPtr(int'(headPtr) + i);
                        if (!headFound && (i < int'(slotCount)))
                        begin
                                if (live[slotIdx] && !squashHit[slotIdx])
                                        headFound = 1'b1;
                                else
                                        skipCount = skipCount + 1'b1;
                        end
                end
                headIdx = wrapPtr(int'(headPtr) + int'(skipCount));
        end

        assign pushSquash = flushValid_i && lane.pushPkt.brMask[flushCheckpoint_i];
        assign pushWrite  = lane.push && !pushSquash;
        assign popNow     = lane.pop && headFound;

        assign lane.headValid = headFound;
        assign lane.headPkt   = entries[headIdx];
        assign lane.credit    = freeCount;

        always_ff @(posedge clk)
        begin
                if (pushWrite)
                        entries[tailPtr] <= lane.pushPkt;
        end

        // Dead slots behind a live head are recycled once the head passes them.
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        live      <= '0;
                        headPtr   <= '0;
                        tailPtr   <= '0;
                        slotCount <= '0;
                        freeCount <= '0;
                end
                else
                begin
                        for (int i = 0; i < LANE_DEPTH; i++)
                        begin
                                if (squashHit[i])
                                        live[i] <= 1'b0;
                        end
                        if (popNow)
                                live[headIdx] <= 1'b0;
                        if (pushWrite)
                        begin
                                live[tailPtr] <= 1'b1;
                                tailPtr       <= wrapPtr(int'(tailPtr) + 1);
                        end
                        headPtr   <= popNow ? wrapPtr(int'(headIdx) + 1) : headIdx;
                        slotCount <= slotCount + CNT_W'(pushWrite) - skipCount
                                     - CNT_W'(popNow);
                        freeCount <= skipCount + CNT_W'(popNow)
                                     + CNT_W'(lane.push && pushSquash);  // Dropped push too.
                end
        end

endmodule

//--- hw/wbCollector.sv
// Round-robin drain of the writeback lanes into one registered completion port.
module wbCollector import wbPkg::*; #(
        parameter int NUM_LANES  = wbPkg::NUM_LANES,
        localparam int LANE_W    = idxWidth(NUM_LANES)
) (
        input  logic              clk,
        input  logic              reset,
        input  logic              flushValid_i,
        input  logic [CHK_W-1:0]  flushCheckpoint_i,
        input  logic              commitReady_i,
        laneIf.collectMp          lanes [NUM_LANES],
        output logic              wbValid_o,
        output fuOp_e             wbOp_o,
        output logic [TAG_W-1:0]  wbTag_o,
        output logic [PREG_W-1:0] wbDest_o,
        output logic [DATA_W-1:0] wbData_o,
        output logic              brTaken_o,
        output logic [PC_W-1:0]   brTarget_o
);

        typedef enum logic {
                COL_EMPTY,
                COL_HOLD
        } colState_e;

        colState_e            state;
        exePacket_t           holdPkt;
        exePacket_t           headPkts [NUM_LANES];
        logic [NUM_LANES-1:0] headValid;
        logic [NUM_LANES-1:0] popVec;
        logic [LANE_W-1:0]    rrPtr;             // Last lane served.
        logic [LANE_W-1:0]    selLane;
        logic                 selFound;
        logic                 accept;
        logic                 heldSquash;
        logic                 load;
        int                   cand;

        for (genvar n = 0; n < NUM_LANES; n++)
        begin : laneGen
                assign headValid[n]  = lanes[n].headValid;
                assign headPkts[n]   = lanes[n].headPkt;
                assign popVec[n]     = load && selFound && (selLane == LANE_W'(n));
                assign lanes[n].pop  = popVec[n];
        end

        always_comb
        begin
                selFound = 1'b0;
                selLane  = '0;
                cand     = 0;
                for (int k = 1; k <= NUM_LANES; k++)
                begin
                        cand = (int'(rrPtr) + k) % NUM_LANES;
                        if (!selFound && headValid[cand])
                        begin
                                selFound = 1'b1;
                                selLane  = LANE_W'(cand);
                        end
                end
        end

        // An accepted completion wins over a flush in the same cycle.
        assign accept     = (state == COL_HOLD) && commitReady_i;
        assign heldSquash = (state == COL_HOLD) && !commitReady_i && flushValid_i
                            && holdPkt.brMask[flushCheckpoint_i];
        assign load       = (state == COL_EMPTY) || accept || heldSquash;

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        state <= COL_EMPTY;
                        rrPtr <= LANE_W'(NUM_LANES - 1);  // Lane 0 goes first.
                end
                else if (load)
                begin
                        if (selFound)
                        begin
                                state <= COL_HOLD;
                                rrPtr <= selLane;
                        end
                        else
                                state <= COL_EMPTY;
                end
        end

        always_ff @(posedge clk)
        begin
                if (load && selFound)
                        holdPkt <= headPkts[selLane];
        end

        assign wbValid_o  = (state == COL_HOLD);
        assign wbOp_o     = holdPkt.op;
        assign wbTag_o    = holdPkt.tag;
        assign wbDest_o   = holdPkt.dest;
        assign wbData_o   = holdPkt.data;
        assign brTaken_o  = (holdPkt.op == OP_BRANCH) ? holdPkt.taken : 1'b0;
        assign brTarget_o = (holdPkt.op == OP_BRANCH) ? holdPkt.target : '0;

endmodule

//--- hw/wbTop.sv
// Writeback stage top level: dispatch, one queue per lane and the completion collector.
module wbTop import wbPkg::*; #(
        parameter int NUM_LANES  = wbPkg::NUM_LANES,
        parameter int LANE_DEPTH = wbPkg::LANE_DEPTH,
        localparam int LANE_W    = idxWidth(NUM_LANES)
) (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   exeValid_i,
        input  logic [LANE_W-1:0]      exeLane_i,
        input  fuOp_e                  exeOp_i,
        input  logic [CHECKPOINTS-1:0] exeBrMask_i,
        input  logic [TAG_W-1:0]       exeTag_i,
        input  logic [PREG_W-1:0]      exeDest_i,
        input  logic [DATA_W-1:0]      exeData_i,
        input  logic [PC_W-1:0]        exeTarget_i,
        input  logic                   exeTaken_i,
        input  logic                   flushValid_i,
        input  logic [CHK_W-1:0]       flushCheckpoint_i,
        input  logic                   commitReady_i,
        output logic [NUM_LANES-1:0]   laneReady_o,
        output logic                   wbValid_o,
        output fuOp_e                  wbOp_o,
        output logic [TAG_W-1:0]       wbTag_o,
        output logic [PREG_W-1:0]      wbDest_o,
        output logic [DATA_W-1:0]      wbData_o,
        output logic                   brTaken_o,
        output logic [PC_W-1:0]        brTarget_o
);

        exePacket_t exePkt;

        laneIf #(.LANE_DEPTH(LANE_DEPTH)) laneBus [NUM_LANES] ();

        assign exePkt = '{
                op:     exeOp_i,
                brMask: exeBrMask_i,
                tag:    exeTag_i,
                dest:   exeDest_i,
                data:   exeData_i,
                target: exeTarget_i,
                taken:  exeTaken_i
        };

        exeDispatch #(
                .NUM_LANES  (NUM_LANES),
                .LANE_DEPTH (LANE_DEPTH)
        ) dispatch_i (
                .clk         (clk),
                .reset       (reset),
                .inValid_i   (exeValid_i),
                .inLane_i    (exeLane_i),
                .inPkt_i     (exePkt),
                .laneReady_o (laneReady_o),
                .lanes       (laneBus)
        );

        for (genvar n = 0; n < NUM_LANES; n++)
        begin : laneGen
                wbLane #(
                        .LANE_DEPTH (LANE_DEPTH)
                ) lane_i (
                        .clk               (clk),
                        .reset             (reset),
                        .flushValid_i      (flushValid_i),
                        .flushCheckpoint_i (flushCheckpoint_i),
                        .lane              (laneBus[n])
                );
        end

        wbCollector #(
                .NUM_LANES (NUM_LANES)
        ) collector_i (
                .clk               (clk),
                .reset             (reset),
                .flushValid_i      (flushValid_i),
                .flushCheckpoint_i (flushCheckpoint_i),
                .commitReady_i     (commitReady_i),
                .lanes             (laneBus),
                .wbValid_o         (wbValid_o),
                .wbOp_o            (wbOp_o),
                .wbTag_o           (wbTag_o),
                .wbDest_o          (wbDest_o),
                .wbData_o          (wbData_o),
                .brTaken_o         (brTaken_o),
                .brTarget_o        (brTarget_o)
        );

endmodule

//--- tb/wbTop_chk.sv
// Protocol assertions bound into the writeback top level for credit use and completion hold.
module wbTop_chk import wbPkg::*; #(
        parameter int NUM_LANES  = wbPkg::NUM_LANES,
        parameter int LANE_DEPTH = wbPkg::LANE_DEPTH,
        localparam int CNT_W     = cntWidth(LANE_DEPTH),
        localparam int HOLD_W    = $bits(fuOp_e) + TAG_W + PREG_W + DATA_W + 1 + PC_W
) (
        input logic                 clk,
        input logic                 reset,
        input logic                 flushValid_i,
        input logic                 commitReady_i,
        input logic [NUM_LANES-1:0] pushVec_i,
        input logic [CNT_W-1:0]     laneFree_i [NUM_LANES],
        input logic [CNT_W-1:0]     creditCount_i [NUM_LANES],
        input logic                 wbValid_i,
        input logic [HOLD_W-1:0]    wbHold_i           // All completion fields.
);

        logic [CNT_W-1:0] slotsTaken [NUM_LANES];      // Pushed and not yet returned.
        int               failCount;

        initial failCount = 0;

        task automatic noteFailure(input string what);
                failCount++;
                $error("%s", what);
        endtask

        always_ff @(posedge clk)
        begin
                for (int n = 0; n < NUM_LANES; n++)
                begin
                        if (reset)
                                slotsTaken[n] <= '0;
                        else
                                slotsTaken[n] <= slotsTaken[n] + CNT_W'(pushVec_i[n])
                                                 - laneFree_i[n];
                end
        end

        for (genvar n = 0; n < NUM_LANES; n++)
        begin : laneGen
                assert property (@(posedge clk) disable iff (reset)
                        pushVec_i[n] |-> slotsTaken[n] < CNT_W'(LANE_DEPTH))
                else
                        noteFailure("push to a lane without credit");

                assert property (@(posedge clk) disable iff (reset)
                        creditCount_i[n] <= CNT_W'(LANE_DEPTH))
                else
                        noteFailure("lane credit count above queue depth");
        end

        // A flush may squash the held packet and load another.
        assert property (@(posedge clk) disable iff (reset)
                wbValid_i && !commitReady_i && !flushValid_i |=> wbValid_i && $stable(wbHold_i))
        else
                noteFailure("completion port changed while commitReady_i was low");

endmodule

bind wbTop wbTop_chk #(
        .NUM_LANES  (NUM_LANES),
        .LANE_DEPTH (LANE_DEPTH)
) chk_i (
        .clk           (clk),
        .reset         (reset),
        .flushValid_i  (flushValid_i),
        .commitReady_i (commitReady_i),
        .pushVec_i     (dispatch_i.pushVec),
        .laneFree_i    (dispatch_i.returned),
        .creditCount_i (dispatch_i.creditCount),
        .wbValid_i     (wbValid_o),
        .wbHold_i      ({wbOp_o, wbTag_o, wbDest_o, wbData_o, brTaken_o, brTarget_o})
);

//--- tb/wbTb.sv
// Table-driven testbench for the writeback stage; run it as the simulation top with wbTop_chk bound.
module wbTb import wbPkg::*; ();
        localparam int LANE_W       = idxWidth(NUM_LANES);
        localparam int SEQ_W        = TAG_W - LANE_W;
        localparam int NUM_TESTS    = 5;
        localparam int READY_ALWAYS = 0;
        localparam int READY_RANDOM = 1;
        localparam int READY_HELD   = 2;

        logic                   clk;
        logic                   reset;
        logic                   exeValid_i;
        logic [LANE_W-1:0]      exeLane_i;
        fuOp_e                  exeOp_i;
        logic [CHECKPOINTS-1:0] exeBrMask_i;
        logic [TAG_W-1:0]       exeTag_i;
        logic [PREG_W-1:0]      exeDest_i;
        logic [DATA_W-1:0]      exeData_i;
        logic [PC_W-1:0]        exeTarget_i;
        logic                   exeTaken_i;
        logic                   flushValid_i;
        logic [CHK_W-1:0]       flushCheckpoint_i;
        logic                   commitReady_i;
        logic [NUM_LANES-1:0]   laneReady_o;
        logic                   wbValid_o;
        fuOp_e                  wbOp_o;
        logic [TAG_W-1:0]       wbTag_o;
        logic [PREG_W-1:0]      wbDest_o;
        logic [DATA_W-1:0]      wbData_o;
        logic                   brTaken_o;
        logic [PC_W-1:0]        brTarget_o;

        exePacket_t             expQ [NUM_LANES][$];   // Expected completions, oldest first.
        exePacket_t             curPkt;
        int                     curLane;
        int                     curTest;
        int                     doneCount;
        int                     testErrors;
        int                     totalErrors;
        int                     failedTests;
        int                     cycles;
        int                     cycleLimit;
        logic [31:0]            rng;

        string                  tName [NUM_TESTS];
        int                     tCount [NUM_TESTS];
        int                     tLane [NUM_TESTS];     // Fixed lane, -1 rotating, -2 random.
        int                     tOp [NUM_TESTS];       // Fixed opcode, -1 rotating.
        int                     tReady [NUM_TESTS];
        int                     tFlush [NUM_TESTS];    // Checkpoint flushed while held.
        logic [NUM_LANES-1:0]   tExpReady [NUM_TESTS]; // Credit state while held.
        int                     tExpDone [NUM_TESTS];

        wbTop #(.NUM_LANES(NUM_LANES), .LANE_DEPTH(LANE_DEPTH)) wbTop_i (.*);

        initial
        begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        task automatic addTest(input int idx, input string name, input int count, input int lane,
                               input int op, input int ready, input int flush,
                               input logic [NUM_LANES-1:0] expReady, input int expDone);
                tName[idx]     = name;
                tCount[idx]    = count;
                tLane[idx]     = lane;
                tOp[idx]       = op;
                tReady[idx]    = ready;
                tFlush[idx]    = flush;
                tExpReady[idx] = expReady;
                tExpDone[idx]  = expDone;
        endtask

        function automatic logic [31:0] xorshift32(input logic [31:0] state);
                logic [31:0] x;
                x = state;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                return x;
        endfunction

        task automatic setReady(input int mode);
                if (mode == READY_RANDOM)
                begin
                        rng = xorshift32(rng);
                        commitReady_i = rng[0];
                end
                else
                        commitReady_i = (mode == READY_ALWAYS);
        endtask

        // Lane number rides in the upper tag bits.
        task automatic makePacket(input int t, input int i);
                if (tLane[t] == -2)
                begin
                        rng = xorshift32(rng);
                        curLane = int'(rng % NUM_LANES);
                end
                else
                        curLane = (tLane[t] == -1) ? i % NUM_LANES : tLane[t];
                rng = xorshift32(rng);
                curPkt.op     = (tOp[t] == -1) ? fuOp_e'(i % 3) : fuOp_e'(tOp[t]);
                curPkt.brMask = CHECKPOINTS'(1 << (i % 5));
                curPkt.tag    = TAG_W'((curLane << SEQ_W) | (i % (1 << SEQ_W)));
                curPkt.dest   = PREG_W'(i + 3 * t);
                curPkt.data   = rng;
                curPkt.target = {rng[15:0], rng[31:16]};
                curPkt.taken  = rng[7];
        endtask

        task automatic compareField(input string test, input string field,
                                    input logic [31:0] expV, input logic [31:0] actV);
                if (expV !== actV)
                begin
                        $display("mismatch test %s %s expected %h actual %h",
                                 test, field, expV, actV);
                        testErrors++;
                end
        endtask

        task automatic squashExpected(input int chk);
                exePacket_t keep [$];
                for (int n = 0; n < NUM_LANES; n++)
                begin
                        keep = {};
                        for (int k = 0; k < expQ[n].size(); k++)
                        begin
                                if (!expQ[n][k].brMask[chk])
                                        keep.push_back(expQ[n][k]);
                        end
                        expQ[n] = keep;
                end
        endtask

        function automatic logic queuesEmpty();
                logic empty;
                empty = 1'b1;
                for (int n = 0; n < NUM_LANES; n++)
                begin
                        if (expQ[n].size() != 0)
                                empty = 1'b0;
                end
                return empty;
        endfunction

        task automatic checkCompletion();
                exePacket_t expPkt;
                int         lane;
                lane = int'(wbTag_o >> SEQ_W);
                doneCount++;
                if (expQ[lane].size() == 0)
                begin
                        $display("test %s: tag %h completed on lane %0d with nothing outstanding",
                                 tName[curTest], wbTag_o, lane);
                        testErrors++;
                end
                else
                begin
                        expPkt = expQ[lane].pop_front();
                        compareField(tName[curTest], "wbTag_o", expPkt.tag, wbTag_o);
                        compareField(tName[curTest], "wbDest_o", expPkt.dest, wbDest_o);
                        compareField(tName[curTest], "wbData_o", expPkt.data, wbData_o);
                        compareField(tName[curTest], "wbOp_o", expPkt.op, wbOp_o);
                        compareField(tName[curTest], "brTaken_o",
                                     (expPkt.op == OP_BRANCH) ? expPkt.taken : 1'b0, brTaken_o);
                        compareField(tName[curTest], "brTarget_o",
                                     (expPkt.op == OP_BRANCH) ? expPkt.target : '0, brTarget_o);
                end
        endtask

        always @(posedge clk)
        begin
                if (!reset && wbValid_o && commitReady_i)
                        checkCompletion();
        end

        initial
        begin
                cycles = 0;
                @(posedge clk);
                while (cycles < cycleLimit)
                begin
                        @(posedge clk);
                        cycles++;
                end
                $display("timeout: run still busy after %0d cycles", cycleLimit);
                $display("SOME TESTS FAILED");
                $finish;
        end

        initial
        begin
                int t;
                int sent;
                addTest(0, "single", NUM_LANES, -1, int'(OP_ALU), READY_ALWAYS, -1, '1, NUM_LANES);
                addTest(1, "branch_fields", 9, -1, -1, READY_ALWAYS, -1, '1, 9);
                addTest(2, "random_ready", 40, -2, -1, READY_RANDOM, -1, '1, 40);
                addTest(3, "backpressure", LANE_DEPTH + 1, 0, int'(OP_LOAD), READY_HELD, -1,
                        ~NUM_LANES'(1), LANE_DEPTH + 1);
                addTest(4, "flush_held", 12, -1, -1, READY_HELD, 0, '1, 9);  // Hits i = 0, 5, 10.
                cycleLimit = 0;
                for (t = 0; t < NUM_TESTS; t++)
                        cycleLimit += tCount[t] * 20;
                rng               = 32'h8934_a1c5;
                totalErrors       = 0;
                failedTests       = 0;
                doneCount         = 0;
                curTest           = 0;
                reset             = 1'b1;
                exeValid_i        = 1'b0;
                exeLane_i         = '0;
                exeOp_i           = OP_ALU;
                exeBrMask_i       = '0;
                exeTag_i          = '0;
                exeDest_i         = '0;
                exeData_i         = '0;
                exeTarget_i       = '0;
                exeTaken_i        = 1'b0;
                flushValid_i      = 1'b0;
                flushCheckpoint_i = '0;
                commitReady_i     = 1'b0;
                repeat (3) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;
                testErrors = 0;
                compareField("reset", "laneReady_o", {NUM_LANES{1'b1}}, laneReady_o);
                compareField("reset", "wbValid_o", 0, wbValid_o);
                totalErrors += testErrors;
                for (t = 0; t < NUM_TESTS; t++)
                begin
                        curTest    = t;
                        testErrors = 0;
                        doneCount  = 0;
                        sent       = 0;
                        makePacket(t, 0);
                        while (sent < tCount[t])
                        begin
                                @(negedge clk);
                                setReady(tReady[t]);
                                exeValid_i = 1'b0;
                                if (laneReady_o[curLane])
                                begin
                                        exeValid_i  = 1'b1;
                                        exeLane_i   = LANE_W'(curLane);
                                        exeOp_i     = curPkt.op;
                                        exeBrMask_i = curPkt.brMask;
                                        exeTag_i    = curPkt.tag;
                                        exeDest_i   = curPkt.dest;
                                        exeData_i   = curPkt.data;
                                        exeTarget_i = curPkt.target;
                                        exeTaken_i  = curPkt.taken;
                                        expQ[curLane].push_back(curPkt);
                                        sent++;
                                        makePacket(t, sent);
                                end
                        end
                        @(negedge clk);
                        exeValid_i = 1'b0;
                        if (tReady[t] == READY_HELD)
                        begin
                                repeat (3) @(negedge clk);
                                compareField(tName[t], "laneReady_o held", tExpReady[t],
                                             laneReady_o);
                                if (tFlush[t] >= 0)
                                begin
                                        flushValid_i      = 1'b1;
                                        flushCheckpoint_i = CHK_W'(tFlush[t]);
                                        squashExpected(tFlush[t]);
                                        @(negedge clk);
                                        flushValid_i = 1'b0;
                                end
                        end
                        while (!queuesEmpty() || wbValid_o)
                        begin
                                @(negedge clk);
                                setReady((tReady[t] == READY_HELD) ? READY_ALWAYS : tReady[t]);
                        end
                        repeat (3) @(negedge clk);                 // Credits settle.
                        compareField(tName[t], "laneReady_o idle", {NUM_LANES{1'b1}}, laneReady_o);
                        compareField(tName[t], "completions", tExpDone[t], doneCount);
                        if (testErrors != 0)
                                failedTests++;
                        totalErrors += testErrors;
                        $display("test %0d %s: %0d sent, %0d completed, %0d errors",
                                 t, tName[t], sent, doneCount, testErrors);
                end
                totalErrors += wbTop_i.chk_i.failCount;
                $display("summary: %0d tests, %0d failed, %0d assertion failures, %0d errors",
                         NUM_TESTS, failedTests, wbTop_i.chk_i.failCount, totalErrors);
                if (totalErrors == 0)
                        $display("ALL TESTS PASSED");
                else
                        $display("SOME TESTS FAILED");
                $finish;
        end

endmodule

//--- filelist.f
hw/wbPkg.sv
hw/laneIf.sv
hw/exeDispatch.sv
hw/wbLane.sv
hw/wbCollector.sv
hw/wbTop.sv
tb/wbTop_chk.sv
tb/wbTb.sv
